// File: include/imu_bridge_defs.svh
`ifndef IMU_BRIDGE_DEFS_SVH
`define IMU_BRIDGE_DEFS_SVH

// UART timing, kept short for simulation
`define CLKS_PER_BIT 16

// SPI clock runs at clk / (2 * CLKS_PER_HALF_BIT)
`define CLKS_PER_HALF_BIT 2

// Idle time that drops a partial frame, 40 bit times
`define FRAME_GAP_CYCLES (40 * `CLKS_PER_BIT)

`define OTP_KEY 16'hA5C3
`define FRAME_TERM 8'h0D

// Command words after the pad is removed
`define CMD_CIPHER_OFF 16'h0001
`define CMD_CIPHER_ON 16'h0002

// Response ids in the low byte of the first word
`define RSP_CIPHER_CTRL 8'h01
`define RSP_IMU_READ 8'h02

`define SPI_READ_FLAG 8'h80

`endif

// File: logic/imu_bridge_pkg.sv
package imu_bridge_pkg;

  // One received UART byte with its strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_strobe_t;

  // Field view of a sensor command
  typedef struct packed {
    logic [12:0] reserved;
    logic [2:0]  imu_reg;  // IMU register select
  } cmd_fields_t;

  // Command word, compared whole or split into fields
  typedef union packed {
    logic [15:0] raw;
    cmd_fields_t fields;
  } cmd_word_u;

  // Sample returned by one SPI read
  typedef struct packed {
    logic        valid;
    logic [15:0] sample;
  } imu_result_t;

endpackage

// File: logic/uart_rx.sv
`timescale 1ns/100ps
`include "imu_bridge_defs.svh"

module uart_rx import imu_bridge_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         i_rx,
  output byte_strobe_t o_byte
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`CLKS_PER_BIT - 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]       rx_sync;
  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             valid;

  assign o_byte = '{valid: valid, data: shift};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_sync <= 2'b11;  // Line idles high
      state   <= S_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid   <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[0], i_rx};
      valid   <= 1'b0;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_sync[1]) begin
            state <= S_START;
          end
        end
        S_START: begin
          if (clk_cnt == HALF_CNT) begin
            clk_cnt <= '0;
            state   <= rx_sync[1] ? S_IDLE : S_DATA;  // Reject short glitch
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt == FULL_CNT) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (clk_cnt == FULL_CNT) begin
            valid <= rx_sync[1];  // Framing error drops the byte
            state <= S_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DATA && clk_cnt == FULL_CNT) begin
      shift <= {rx_sync[1], shift[7:1]};  // LSB arrives first
    end
  end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/100ps
`include "imu_bridge_defs.svh"

module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic       i_start,
  input  logic [7:0] i_data,
  output logic       o_busy,
  output logic       o_tx
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`CLKS_PER_BIT - 1);

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;
  logic [9:0]       frame;  // Stop, data, start

  assign o_tx = !o_busy || frame[0];  // High when idle

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      o_busy  <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!o_busy) begin
      clk_cnt <= '0;
      bit_idx <= '0;
      if (i_start) begin
        o_busy <= 1'b1;
      end
    end else if (clk_cnt == FULL_CNT) begin
      clk_cnt <= '0;
      bit_idx <= bit_idx + 1'b1;
      if (bit_idx == 4'd9) begin
        o_busy <= 1'b0;  // End of stop bit
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!o_busy && i_start) begin
      frame <= {1'b1, i_data, 1'b0};
    end else if (o_busy && clk_cnt == FULL_CNT) begin
      frame <= {1'b1, frame[9:1]};  // LSB first
    end
  end

endmodule

// File: logic/frame_accumulator.sv
`timescale 1ns/100ps
`include "imu_bridge_defs.svh"

module frame_accumulator import imu_bridge_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  byte_strobe_t i_byte,
  output logic         o_frame_valid,
  output cmd_word_u    o_cmd
);

  localparam int GAP_W = $clog2(`FRAME_GAP_CYCLES + 1);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`FRAME_GAP_CYCLES - 1);

  logic [1:0]       byte_cnt;  // Bytes of the current frame
  logic [GAP_W-1:0] gap_cnt;
  logic [15:0]      payload;
  logic             term_ok;

  assign term_ok = i_byte.valid && byte_cnt == 2'd2 && i_byte.data == `FRAME_TERM;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      byte_cnt      <= '0;
      gap_cnt       <= '0;
      o_frame_valid <= 1'b0;
    end else begin
      o_frame_valid <= term_ok;
      if (i_byte.valid) begin
        gap_cnt  <= '0;
        byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 1'b1;
      end else if (byte_cnt != 2'd0) begin
        if (gap_cnt == GAP_LAST) begin
          gap_cnt  <= '0;
          byte_cnt <= '0;  // Partial frame timed out
        end else begin
          gap_cnt <= gap_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_byte.valid && byte_cnt == 2'd0) begin
      payload[7:0] <= i_byte.data;
    end
    if (i_byte.valid && byte_cnt == 2'd1) begin
      payload[15:8] <= i_byte.data;
    end
    if (term_ok) begin
      o_cmd.raw <= payload;
    end
  end

endmodule

// File: logic/spi_master.sv
`timescale 1ns/100ps
`include "imu_bridge_defs.svh"

module spi_master import imu_bridge_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_start,
  input  logic [2:0]  i_reg,
  input  logic        i_miso,
  output imu_result_t o_result,
  output logic        o_spi_clk,
  output logic        o_spi_mosi,
  output logic        o_spi_cs_n
);

  localparam int HALF_W = $clog2(`CLKS_PER_HALF_BIT + 1);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`CLKS_PER_HALF_BIT - 1);
  localparam logic [5:0] LAST_EDGE = 6'd47;  // 24 bits, two edges each

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_XFER = 2'd1;
  localparam logic [1:0] S_END  = 2'd2;

  logic [1:0]        state;
  logic [HALF_W-1:0] half_cnt;
  logic [5:0]        edge_cnt;
  logic [7:0]        addr_byte;
  logic [23:0]       tx_shift;
  logic [15:0]       rx_shift;
  logic              valid;
  logic              tick;

  assign addr_byte = `SPI_READ_FLAG | {5'd0, i_reg};
  assign tick      = (state == S_XFER) && (half_cnt == HALF_LAST);
  // First byte read is the low half
  assign o_result  = '{valid: valid, sample: {rx_shift[7:0], rx_shift[15:8]}};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= S_IDLE;
      half_cnt   <= '0;
      edge_cnt   <= '0;
      o_spi_clk  <= 1'b0;
      o_spi_mosi <= 1'b0;
      o_spi_cs_n <= 1'b1;
      valid      <= 1'b0;
    end else begin
      valid <= 1'b0;
      case (state)
        S_IDLE: begin
          half_cnt <= '0;
          edge_cnt <= '0;
          if (i_start) begin
            o_spi_cs_n <= 1'b0;
            o_spi_mosi <= addr_byte[7];  // Mode 0, first bit before first edge
            state      <= S_XFER;
          end
        end
        S_XFER: begin
          if (tick) begin
            half_cnt  <= '0;
            edge_cnt  <= edge_cnt + 1'b1;
            o_spi_clk <= !o_spi_clk;
            if (o_spi_clk) begin
              o_spi_mosi <= tx_shift[23];  // Shift on falling edge
            end
            if (edge_cnt == LAST_EDGE) begin
              o_spi_mosi <= 1'b0;
              state      <= S_END;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        S_END: begin
          o_spi_cs_n <= 1'b1;
          valid      <= 1'b1;
          state      <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_start) begin
      tx_shift <= {addr_byte[6:0], 17'd0};
    end else if (tick && o_spi_clk) begin
      tx_shift <= tx_shift << 1;
    end
    if (tick && !o_spi_clk) begin
      rx_shift <= {rx_shift[14:0], i_miso};  // Sample on rising edge
    end
  end

endmodule

// File: logic/bridge_sequencer.sv
`timescale 1ns/100ps
`include "imu_bridge_defs.svh"

module bridge_sequencer import imu_bridge_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_frame_valid,
  input  cmd_word_u   i_cmd,
  input  imu_result_t i_result,
  input  logic        i_tx_busy,
  output logic        o_spi_start,
  output logic [2:0]  o_spi_reg,
  output logic        o_tx_start,
  output logic [7:0]  o_tx_data
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_SPI  = 2'd1;  // Waiting for the IMU sample
  localparam logic [1:0] S_HOLD = 2'd2;  // Start pulse cycle
  localparam logic [1:0] S_WAIT = 2'd3;  // Waiting for the byte to finish

  logic [1:0]  state;
  logic        cipher_on;
  logic        cipher_next;
  logic        is_cipher_cmd;
  cmd_word_u   plain;
  logic [2:0]  bytes_left;
  logic [39:0] rsp;  // Five bytes, next one in the low byte

  // Two words plus terminator, each word XORed with the pad when enabled
  function automatic logic [39:0] build_rsp(input logic [15:0] w0, input logic [15:0] w1,
                                            input logic enc);
    logic [15:0] pad;
    pad = enc ? `OTP_KEY : 16'h0000;
    return {`FRAME_TERM, w1 ^ pad, w0 ^ pad};
  endfunction

  always_comb begin
    plain.raw     = i_cmd.raw ^ (cipher_on ? `OTP_KEY : 16'h0000);
    cipher_next   = (plain.raw == `CMD_CIPHER_ON);
    is_cipher_cmd = cipher_next || (plain.raw == `CMD_CIPHER_OFF);
  end

  assign o_tx_data = rsp[7:0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= S_IDLE;
      cipher_on   <= 1'b0;
      bytes_left  <= '0;
      o_spi_start <= 1'b0;
      o_tx_start  <= 1'b0;
    end else begin
      o_spi_start <= 1'b0;
      o_tx_start  <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_frame_valid) begin
            bytes_left <= 3'd4;
            if (is_cipher_cmd) begin
              cipher_on  <= cipher_next;  // Reply goes out under the new setting
              o_tx_start <= 1'b1;
              state      <= S_HOLD;
            end else begin
              o_spi_start <= 1'b1;
              state       <= S_SPI;
            end
          end
        end
        S_SPI: begin
          if (i_result.valid) begin
            o_tx_start <= 1'b1;
            state      <= S_HOLD;
          end
        end
        S_HOLD: state <= S_WAIT;  // Busy is not up yet
        default: begin
          if (!i_tx_busy) begin
            if (bytes_left == 3'd0) begin
              state <= S_IDLE;
            end else begin
              bytes_left <= bytes_left - 1'b1;
              o_tx_start <= 1'b1;
              state      <= S_HOLD;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_frame_valid && is_cipher_cmd) begin
      rsp <= build_rsp({8'h00, `RSP_CIPHER_CTRL}, 16'h0000, cipher_next);
    end else if (state == S_SPI && i_result.valid) begin
      rsp <= build_rsp({i_result.sample[7:0], `RSP_IMU_READ},
                       {8'h00, i_result.sample[15:8]}, cipher_on);
    end else if (state == S_WAIT && !i_tx_busy && bytes_left != 3'd0) begin
      rsp <= {8'h00, rsp[39:8]};
    end
    if (state == S_IDLE && i_frame_valid && !is_cipher_cmd) begin
      o_spi_reg <= plain.fields.imu_reg;
    end
  end

endmodule

// File: logic/imu_bridge_top.sv
`timescale 1ns/100ps

module imu_bridge_top import imu_bridge_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic i_uart_rx,
  output logic o_uart_tx,
  output logic o_spi_clk,
  input  logic i_spi_miso,
  output logic o_spi_mosi,
  output logic o_spi_cs_n
);

  byte_strobe_t rx_byte;
  logic         frame_valid;
  cmd_word_u    cmd;  // Still ciphered
  logic         spi_start;
  logic [2:0]   spi_reg;
  imu_result_t  imu_result;
  logic         tx_start;
  logic [7:0]   tx_data;
  logic         tx_busy;

  uart_rx u_uart_rx (
    .clk    (clk),
    .reset  (reset),
    .i_rx   (i_uart_rx),
    .o_byte (rx_byte)
  );

  frame_accumulator u_frame_accumulator (
    .clk           (clk),
    .reset         (reset),
    .i_byte        (rx_byte),
    .o_frame_valid (frame_valid),
    .o_cmd         (cmd)
  );

  bridge_sequencer u_bridge_sequencer (
    .clk           (clk),
    .reset         (reset),
    .i_frame_valid (frame_valid),
    .i_cmd         (cmd),
    .i_result      (imu_result),
    .i_tx_busy     (tx_busy),
    .o_spi_start   (spi_start),
    .o_spi_reg     (spi_reg),
    .o_tx_start    (tx_start),
    .o_tx_data     (tx_data)
  );

  spi_master u_spi_master (
    .clk        (clk),
    .reset      (reset),
    .i_start    (spi_start),
    .i_reg      (spi_reg),
    .i_miso     (i_spi_miso),
    .o_result   (imu_result),
    .o_spi_clk  (o_spi_clk),
    .o_spi_mosi (o_spi_mosi),
    .o_spi_cs_n (o_spi_cs_n)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .reset   (reset),
    .i_start (tx_start),
    .i_data  (tx_data),
    .o_busy  (tx_busy),
    .o_tx    (o_uart_tx)
  );

endmodule

// File: bench/imu_bridge_props.sv
`timescale 1ns/100ps

module imu_bridge_props (
  input logic clk,
  input logic reset,
  input logic i_uart_tx,
  input logic i_spi_clk,
  input logic i_spi_cs_n
);

  int error_count = 0;  // Failed property count

  // SPI clock idles low outside a transaction
  assert property (@(posedge clk) disable iff (reset) i_spi_cs_n |-> !i_spi_clk)
    else begin
      $error("SPI clock high while chip select is high");
      error_count++;
    end

  assert property (@(posedge clk) reset |-> i_spi_cs_n)
    else begin
      $error("chip select low during reset");
      error_count++;
    end

  // UART line idles high once reset is released
  assert property (@(posedge clk) $fell(reset) |-> i_uart_tx)
    else begin
      $error("UART output low in the cycle after reset");
      error_count++;
    end

endmodule

bind imu_bridge_top imu_bridge_props u_props (
  .clk        (clk),
  .reset      (reset),
  .i_uart_tx  (o_uart_tx),
  .i_spi_clk  (o_spi_clk),
  .i_spi_cs_n (o_spi_cs_n)
);

// File: bench/imu_bridge_tb.sv
`timescale 1ns/100ps
`include "imu_bridge_defs.svh"

module imu_bridge_tb;

  localparam int QUIET_CYCLES = 40 * `CLKS_PER_BIT;
  localparam int RSP_TIMEOUT  = 20 * `CLKS_PER_BIT + 60 * `CLKS_PER_HALF_BIT;

  logic clk = 1'b0;
  logic reset;
  logic i_uart_rx;
  logic o_uart_tx;
  logic o_spi_clk;
  logic i_spi_miso;
  logic o_spi_mosi;
  logic o_spi_cs_n;

  logic [15:0] imu_table [8];  // Sample held by each IMU register
  logic        cipher_model = 1'b0;
  logic [7:0]  rx_q [$];  // Bytes seen on o_uart_tx
  logic [7:0]  spi_addr_q [$];  // Address byte of each SPI transaction

  // UART monitor state
  logic        mon_busy = 1'b0;
  int          mon_cnt;
  int          mon_bit;
  logic [7:0]  mon_data;

  // IMU model state
  logic        cs_prev = 1'b1;
  logic        sclk_prev = 1'b0;
  int          spi_bits;
  logic [7:0]  spi_addr;
  logic [15:0] spi_sample;
  logic [15:0] read_bits;

  imu_bridge_top i_imu_bridge_top (
    .clk        (clk),
    .reset      (reset),
    .i_uart_rx  (i_uart_rx),
    .o_uart_tx  (o_uart_tx),
    .o_spi_clk  (o_spi_clk),
    .i_spi_miso (i_spi_miso),
    .o_spi_mosi (o_spi_mosi),
    .o_spi_cs_n (o_spi_cs_n)
  );

  always #50 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Watches the bound property checker
  always @(posedge clk) begin
    #1;
    assert (i_imu_bridge_top.u_props.error_count == 0)
      else fail_now("a concurrent property failed in the bound checker");
  end

  // Receives bytes from the DUT at bit centres
  always @(posedge clk) begin
    #1;
    if (reset) begin
      mon_busy = 1'b0;
    end else if (!mon_busy) begin
      if (!o_uart_tx) begin
        mon_busy = 1'b1;  // Start bit began on this edge
        mon_cnt  = 0;
      end
    end else begin
      mon_cnt++;
      if (mon_cnt % `CLKS_PER_BIT == `CLKS_PER_BIT / 2) begin
        mon_bit = mon_cnt / `CLKS_PER_BIT;
        if (mon_bit == 0) begin
          assert (o_uart_tx == 1'b0) else fail_now($sformatf(
            "error at %0t ns: o_uart_tx start bit got %b expected 0", $time, o_uart_tx));
        end else if (mon_bit <= 8) begin
          mon_data[mon_bit-1] = o_uart_tx;  // LSB first
        end else begin
          assert (o_uart_tx == 1'b1) else fail_now($sformatf(
            "error at %0t ns: o_uart_tx stop bit got %b expected 1", $time, o_uart_tx));
          rx_q.push_back(mon_data);
          mon_busy = 1'b0;
        end
      end
    end
  end

  // IMU slave in SPI mode 0 that changes MISO after each falling edge
  always @(posedge clk) begin
    #1;
    if (!o_spi_cs_n && cs_prev) begin
      spi_bits   = 0;
      spi_addr   = 8'h00;
      i_spi_miso = 1'b0;
    end else if (!o_spi_cs_n) begin
      if (o_spi_clk && !sclk_prev) begin
        if (spi_bits < 8) begin
          spi_addr = {spi_addr[6:0], o_spi_mosi};
        end
        spi_bits++;
      end else if (!o_spi_clk && sclk_prev && spi_bits >= 8 && spi_bits < 24) begin
        spi_sample = imu_table[spi_addr[2:0]];
        read_bits  = {spi_sample[7:0], spi_sample[15:8]};  // Low byte goes out first
        i_spi_miso = read_bits[23 - spi_bits];
      end
    end else if (!cs_prev) begin
      assert (spi_bits == 24) else fail_now($sformatf(
        "error at %0t ns: o_spi_clk pulse count got %0d expected 24", $time, spi_bits));
      spi_addr_q.push_back(spi_addr);
      i_spi_miso = 1'b0;
    end
    cs_prev   = o_spi_cs_n;
    sclk_prev = o_spi_clk;
  end

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int k = 0; k < 10; k++) begin
      i_uart_rx = bits[k];
      wait_cycles(`CLKS_PER_BIT);
    end
  endtask

  task automatic send_frame(input logic [15:0] word, input logic [7:0] term);
    send_byte(word[7:0]);
    send_byte(word[15:8]);
    send_byte(term);
  endtask

  task automatic expect_quiet(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      assert (o_uart_tx === 1'b1) else fail_now($sformatf(
        "error at %0t ns: o_uart_tx got %b expected 1 while idle", $time, o_uart_tx));
      assert (o_spi_cs_n === 1'b1) else fail_now($sformatf(
        "error at %0t ns: o_spi_cs_n got %b expected 1 while idle", $time, o_spi_cs_n));
      wait_cycles(1);
    end
    assert (rx_q.size() == 0 && spi_addr_q.size() == 0)
      else fail_now("DUT answered or used SPI when it should have stayed idle");
  endtask

  task automatic collect_response(input logic [39:0] exp_rsp);
    int          waited;
    logic [7:0]  got;
    for (int i = 0; i < 5; i++) begin
      waited = 0;
      while (rx_q.size() == 0 && waited < RSP_TIMEOUT) begin
        wait_cycles(1);
        waited++;
      end
      assert (rx_q.size() != 0)
        else fail_now($sformatf("timed out waiting for response byte %0d", i));
      got = rx_q.pop_front();
      assert (got == exp_rsp[8*i +: 8]) else fail_now($sformatf(
        "error at %0t ns: o_uart_tx byte %0d got %h expected %h",
        $time, i, got, exp_rsp[8*i +: 8]));
    end
  endtask

  function automatic logic [15:0] random_sensor_cmd();
    logic [15:0] w;
    w = 16'($urandom);
    while (w == `CMD_CIPHER_OFF || w == `CMD_CIPHER_ON) begin
      w = 16'($urandom);
    end
    return w;
  endfunction

  // Sends one command padded by the host and checks the reply against the model
  task automatic run_command(input logic [15:0] plain);
    logic [15:0] sample;
    logic [15:0] pad;
    logic [39:0] exp_rsp;
    logic [7:0]  exp_addr;
    logic [7:0]  got_addr;
    logic        is_cipher;
    is_cipher = (plain == `CMD_CIPHER_ON) || (plain == `CMD_CIPHER_OFF);
    pad = cipher_model ? `OTP_KEY : 16'h0000;
    send_frame(plain ^ pad, `FRAME_TERM);
    if (is_cipher) begin
      cipher_model = (plain == `CMD_CIPHER_ON);
      pad = cipher_model ? `OTP_KEY : 16'h0000;  // Reply uses the new setting
      exp_rsp = {`FRAME_TERM, 16'h0000 ^ pad, {8'h00, `RSP_CIPHER_CTRL} ^ pad};
    end else begin
      sample  = imu_table[plain[2:0]];
      exp_rsp = {`FRAME_TERM, {8'h00, sample[15:8]} ^ pad, {sample[7:0], `RSP_IMU_READ} ^ pad};
    end
    collect_response(exp_rsp);
    if (is_cipher) begin
      assert (spi_addr_q.size() == 0) else fail_now("SPI transaction seen for a cipher command");
    end else begin
      assert (spi_addr_q.size() == 1) else fail_now($sformatf(
        "expected one SPI transaction for a sensor command, saw %0d", spi_addr_q.size()));
      exp_addr = `SPI_READ_FLAG | {5'd0, plain[2:0]};
      got_addr = spi_addr_q.pop_front();
      assert (got_addr == exp_addr) else fail_now($sformatf(
        "error at %0t ns: o_spi_mosi address got %h expected %h", $time, got_addr, exp_addr));
    end
  endtask

  initial begin
    logic [15:0] plain;
    int          pick;
    void'($urandom(32'h8c944b1f));
    reset      = 1'b0;
    i_uart_rx  = 1'b1;
    i_spi_miso = 1'b0;
    for (int r = 0; r < 8; r++) begin
      imu_table[r] = 16'($urandom);
    end
    #1;
    reset = 1'b1;  // Rising edge starts the asynchronous reset
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset state and idle line
    assert (o_uart_tx === 1'b1) else fail_now($sformatf(
      "error at %0t ns: o_uart_tx got %b expected 1", $time, o_uart_tx));
    assert (o_spi_cs_n === 1'b1) else fail_now($sformatf(
      "error at %0t ns: o_spi_cs_n got %b expected 1", $time, o_spi_cs_n));
    expect_quiet(QUIET_CYCLES);

    for (int n = 0; n < 30; n++) begin
      run_command(random_sensor_cmd());  // Cipher still off
    end

    for (int n = 0; n < 40; n++) begin
      pick = $urandom_range(2, 0);
      if (pick == 0) begin
        plain = `CMD_CIPHER_ON;
      end else if (pick == 1) begin
        plain = `CMD_CIPHER_OFF;
      end else begin
        plain = random_sensor_cmd();
      end
      run_command(plain);
    end

    // Bit 4 set keeps the third byte off the terminator
    send_frame(random_sensor_cmd(), 8'($urandom) | 8'h10);
    expect_quiet(QUIET_CYCLES);
    run_command(random_sensor_cmd());

    send_byte(8'($urandom));
    expect_quiet(`FRAME_GAP_CYCLES + 4 * `CLKS_PER_BIT);
    run_command(random_sensor_cmd());

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
logic/imu_bridge_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/frame_accumulator.sv
logic/spi_master.sv
logic/bridge_sequencer.sv
logic/imu_bridge_top.sv
bench/imu_bridge_props.sv
bench/imu_bridge_tb.sv
